//--- hdl/bd_pkg.sv
`default_nettype none

package bd_pkg;

  ////////////////////////////////////////////////////////////
  // word widths

  localparam int unsigned n_code    = 6;
  localparam int unsigned n_payload = 24;
  localparam int unsigned n_bd_data = 21;
  localparam int unsigned n_route   = 8;
  localparam int unsigned n_leaves  = 34;

  // programming leaves, sent by the host as two halves each
  localparam logic [n_code-1:0] code_ammm = 6'd26;
  localparam logic [n_code-1:0] code_pat  = 6'd27;
  localparam logic [n_code-1:0] code_tat0 = 6'd28;
  localparam logic [n_code-1:0] code_tat1 = 6'd29;

  // unencoded host word
  typedef struct packed {
    logic [n_code-1:0]    code;
    logic [n_payload-1:0] payload;
  } bd_word_t;

  ////////////////////////////////////////////////////////////
  // horn routes, indexed by leaf code

  // wiki routes with the bit order flipped, zero-padded to 8 bits
  // the chip takes the route lsb first
  localparam logic [n_route-1:0] route_table [n_leaves] = '{
    // 0..3: adc, dac[0], dac[10], dac[11]
    8'b00000101, 8'b00001101, 8'b01011101, 8'b00111101,
    // 4..7: dac[12], dac[1], dac[2], dac[3]
    8'b01111101, 8'b10001101, 8'b01001101, 8'b11001101,
    // 8..11: dac[4] to dac[7]
    8'b00101101, 8'b10101101, 8'b01101101, 8'b11101101,
    // 12..15: dac[8], dac[9], delay[0], delay[1]
    8'b00011101, 8'b10011101, 8'b00000001, 8'b00100001,
    // 16..19: delay[2] to delay[5]
    8'b01110001, 8'b11110001, 8'b00001001, 8'b00011001,
    // 20..23: delay[6], init fifo dct, init fifo ht, neuron config
    8'b01011001, 8'b00110001, 8'b00010001, 8'b00000011,
    // 24..27: dump toggle, inject, prog ammm, prog pat
    8'b00001111, 8'b00000111, 8'b00111001, 8'b00101001,
    // 28..31: prog tat0, prog tat1, ri, toggle post fifo 0
    8'b01000001, 8'b01100001, 8'b00000000, 8'b01010001,
    // 32..33: toggle post fifo 1, toggle pre fifo
    8'b11010001, 8'b10010001
  };

  // number of route bits per leaf, which is also the payload shift
  localparam logic [3:0] route_len_table [n_leaves] = '{
    4'd4, 4'd8, 4'd7, 4'd7, 4'd7, 4'd8, 4'd8, 4'd8,
    4'd8, 4'd8, 4'd8, 4'd8, 4'd8, 4'd8, 4'd7, 4'd7,
    4'd8, 4'd8, 4'd6, 4'd7, 4'd7, 4'd7, 4'd8, 4'd3,
    4'd4, 4'd4, 4'd6, 4'd6, 4'd7, 4'd7, 4'd1, 4'd8,
    4'd8, 4'd8
  };

endpackage

`default_nettype wire

//--- hdl/bd_word_if.sv
`timescale 1ns/100ps
`default_nettype none

// one unencoded word plus valid/ack handshake
// a word moves on a clock edge with valid and ack both high
interface bd_word_if;

  logic             valid;
  bd_pkg::bd_word_t word;
  logic             ack;

  // producer side holds valid and word until acked
  modport source (
    output valid,
    output word,
    input  ack
  );

  // consumer side may look at valid before raising ack
  modport sink (
    input  valid,
    input  word,
    output ack
  );

endinterface

`default_nettype wire

//--- hdl/bd_leaf_splitter.sv
`timescale 1ns/100ps
`default_nettype none

// sorts host words by leaf code
// programming leaves go to their own lane, everything else to bypass
module bd_leaf_splitter (
  bd_word_if.sink   words_in,
  bd_word_if.source prog_out [4],
  bd_word_if.source bypass_out
);

  // lane order matches the reformatter instances in the top level
  localparam logic [bd_pkg::n_code-1:0] prog_codes [4] = '{
    bd_pkg::code_ammm,
    bd_pkg::code_pat,
    bd_pkg::code_tat0,
    bd_pkg::code_tat1
  };

  logic [3:0] prog_hit;
  logic [3:0] prog_ack;
  logic       is_bypass;

  ////////////////////////////////////////////////////////////
  // programming lanes

  for (genvar i = 0; i < 4; i++) begin : g_prog_lane
    assign prog_hit[i]       = (words_in.word.code == prog_codes[i]);
    // only the matching lane sees valid, all lanes see the word
    assign prog_out[i].valid = words_in.valid & prog_hit[i];
    assign prog_out[i].word  = words_in.word;
    assign prog_ack[i]       = prog_out[i].ack;
  end

  ////////////////////////////////////////////////////////////
  // bypass lane

  // includes codes >= 34, the funnel encoder drops those later
  assign is_bypass        = ~(|prog_hit);
  assign bypass_out.valid = words_in.valid & is_bypass;
  assign bypass_out.word  = words_in.word;

  // ack back from whichever lane the code selects
  assign words_in.ack = (|(prog_ack & prog_hit)) | (bypass_out.ack & is_bypass);

endmodule

`default_nettype wire

//--- hdl/bd_prog_reformatter.sv
`timescale 1ns/100ps
`default_nettype none

// programming leaf reformatter
// the host sends one programming word as two halves,
// the chip wants it as four chunks, low chunk first:
//   chunk 0 = half0 low bits
//   chunk 1 = half0 high bits, zero padded
//   chunk 2 = half1 low bits
//   chunk 3 = half1 high bits, zero padded
module bd_prog_reformatter #(
  parameter logic [bd_pkg::n_code-1:0] leaf_code   = bd_pkg::code_ammm,
  parameter int unsigned               half_width  = 21,
  parameter int unsigned               chunk_width = 11
) (
  input  logic      clk,
  input  logic      rst,
  bd_word_if.sink   halves_in,
  bd_word_if.source chunks_out
);

  // bits left over in each half after the low chunk
  localparam int unsigned hi_width = half_width - chunk_width;

  logic                          have_half0;
  logic                          busy;
  logic [1:0]                    chunk_idx;
  logic [half_width-1:0]         half0;
  logic [half_width-1:0]         half1;
  logic [half_width-1:0]         cur_half;
  logic [bd_pkg::n_payload-1:0]  chunk;
  logic                          in_xfer;
  logic                          out_xfer;

  ////////////////////////////////////////////////////////////
  // handshakes

  // no new halves while chunks are still going out
  assign halves_in.ack = ~busy;
  assign in_xfer       = halves_in.valid & halves_in.ack;
  assign out_xfer      = chunks_out.valid & chunks_out.ack;

  ////////////////////////////////////////////////////////////
  // control

  always_ff @(posedge clk) begin
    if (rst) begin
      have_half0 <= 1'b0;
      busy       <= 1'b0;
      chunk_idx  <= 2'd0;
    end else begin
      if (in_xfer) begin
        have_half0 <= ~have_half0;
        // second half in, chunk 0 valid next cycle
        if (have_half0) begin
          busy <= 1'b1;
        end
      end
      if (out_xfer) begin
        // wraps back to 0 after chunk 3
        chunk_idx <= chunk_idx + 2'd1;
        if (chunk_idx == 2'd3) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // half storage, first half lands in half0
  always_ff @(posedge clk) begin
    if (in_xfer) begin
      if (!have_half0) begin
        half0 <= halves_in.word.payload[half_width-1:0];
      end else begin
        half1 <= halves_in.word.payload[half_width-1:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // chunk select

  // idx[1] picks the half, idx[0] picks low or high part
  assign cur_half = chunk_idx[1] ? half1 : half0;

  always_comb begin
    chunk = '0;
    if (!chunk_idx[0]) begin
      chunk[chunk_width-1:0] = cur_half[chunk_width-1:0];
    end else begin
      chunk[hi_width-1:0] = cur_half[half_width-1:chunk_width];
    end
  end

  assign chunks_out.valid        = busy;
  assign chunks_out.word.code    = leaf_code;
  assign chunks_out.word.payload = chunk;

endmodule

`default_nettype wire

//--- hdl/bd_word_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

// five-way round-robin merge into one registered output word
// lanes 0..3 are programming chunks, lane 4 is bypass
module bd_word_arbiter (
  input  logic      clk,
  input  logic      rst,
  bd_word_if.sink   lanes_in [5],
  bd_word_if.source merged_out
);

  localparam int unsigned n_lanes = 5;

  logic [n_lanes-1:0] req;
  logic [n_lanes-1:0] grant;
  logic [2:0]         grant_idx;
  logic               any_grant;
  logic [2:0]         ptr;
  logic               can_load;
  logic               out_valid;
  bd_pkg::bd_word_t   out_word;
  bd_pkg::bd_word_t   lane_word [n_lanes];

  for (genvar i = 0; i < n_lanes; i++) begin : g_lane
    assign req[i]          = lanes_in[i].valid;
    assign lane_word[i]    = lanes_in[i].word;
    assign lanes_in[i].ack = grant[i];
  end

  // output slot is free or being taken this cycle
  assign can_load = ~out_valid | merged_out.ack;

  ////////////////////////////////////////////////////////////
  // round-robin pick

  // search starts one past the last winner
  always_comb begin
    int unsigned idx;
    grant     = '0;
    grant_idx = ptr;
    any_grant = 1'b0;
    for (int k = 1; k <= n_lanes; k++) begin
      idx = ptr + k;
      if (idx >= n_lanes) begin
        idx = idx - n_lanes;
      end
      if (can_load && !any_grant && req[idx]) begin
        any_grant = 1'b1;
        grant_idx = 3'(idx);
      end
    end
    grant[grant_idx] = any_grant;
  end

  ////////////////////////////////////////////////////////////
  // output register

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      ptr       <= 3'd0;
    end else if (any_grant) begin
      out_valid <= 1'b1;
      ptr       <= grant_idx;
    end else if (merged_out.ack) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (any_grant) begin
      out_word <= lane_word[grant_idx];
    end
  end

  assign merged_out.valid = out_valid;
  assign merged_out.word  = out_word;

endmodule

`default_nettype wire

//--- hdl/bd_funnel_encoder.sv
`timescale 1ns/100ps
`default_nettype none

// leaf code -> horn route encoding
// chip word layout: [ unused | payload | route ]
module bd_funnel_encoder (
  bd_word_if.sink                      words_in,
  output logic                         bd_valid,
  output logic [bd_pkg::n_bd_data-1:0] bd_data,
  input  logic                         bd_ack
);

  logic                                       leaf_ok;
  logic [bd_pkg::n_code-1:0]                  leaf_idx;
  logic [bd_pkg::n_route-1:0]                 route;
  logic [3:0]                                 route_len;
  logic [bd_pkg::n_bd_data-1:0]               route_ext;
  logic [bd_pkg::n_payload+bd_pkg::n_route-1:0] payload_ext;
  logic [bd_pkg::n_payload+bd_pkg::n_route-1:0] payload_shifted;

  ////////////////////////////////////////////////////////////
  // table lookup

  // codes past the table have no route
  assign leaf_ok  = (words_in.word.code < bd_pkg::n_leaves);
  // keep the index in range, result is unused for bad codes
  assign leaf_idx = leaf_ok ? words_in.word.code : '0;

  assign route     = bd_pkg::route_table[leaf_idx];
  assign route_len = bd_pkg::route_len_table[leaf_idx];

  ////////////////////////////////////////////////////////////
  // word assembly

  // widen before shifting so nothing falls off the top early
  assign payload_ext     = {{bd_pkg::n_route{1'b0}}, words_in.word.payload};
  assign payload_shifted = payload_ext << route_len;
  assign route_ext       = {{(bd_pkg::n_bd_data - bd_pkg::n_route){1'b0}}, route};

  // anything above 21 bits is cut off here
  assign bd_data = payload_shifted[bd_pkg::n_bd_data-1:0] | route_ext;

  ////////////////////////////////////////////////////////////
  // handshake

  // bad codes never reach the chip
  assign bd_valid = words_in.valid & leaf_ok;

  // a bad code is swallowed as soon as it shows up
  assign words_in.ack = leaf_ok ? bd_ack : words_in.valid;

endmodule

`default_nettype wire

//--- hdl/bd_encoder.sv
`timescale 1ns/100ps
`default_nettype none

// downstream encoder top
// host words in, 21-bit chip words out
module bd_encoder #(
  parameter int unsigned ammm_half_width  = 21,
  parameter int unsigned ammm_chunk_width = 11,
  parameter int unsigned pat_half_width   = 14,
  parameter int unsigned pat_chunk_width  = 7,
  parameter int unsigned tat0_half_width  = 16,
  parameter int unsigned tat0_chunk_width = 8,
  parameter int unsigned tat1_half_width  = 16,
  parameter int unsigned tat1_chunk_width = 8
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         in_valid,
  input  logic [bd_pkg::n_code-1:0]    in_code,
  input  logic [bd_pkg::n_payload-1:0] in_payload,
  output logic                         in_ack,
  output logic                         out_valid,
  output logic [bd_pkg::n_bd_data-1:0] out_data,
  input  logic                         out_ack
);

  bd_word_if in_if ();
  bd_word_if prog_if [4] ();
  bd_word_if bypass_if ();
  bd_word_if chunk_if [4] ();
  bd_word_if lane_if [5] ();
  bd_word_if merged_if ();

  // host side ports onto the word channel
  assign in_if.valid        = in_valid;
  assign in_if.word.code    = in_code;
  assign in_if.word.payload = in_payload;
  assign in_ack             = in_if.ack;

  ////////////////////////////////////////////////////////////
  // split by leaf, reformat programming leaves

  bd_leaf_splitter i_splitter (
    .words_in   (in_if),
    .prog_out   (prog_if),
    .bypass_out (bypass_if)
  );

  bd_prog_reformatter #(
    .leaf_code   (bd_pkg::code_ammm),
    .half_width  (ammm_half_width),
    .chunk_width (ammm_chunk_width)
  ) i_ammm (
    .clk        (clk),
    .rst        (rst),
    .halves_in  (prog_if[0]),
    .chunks_out (chunk_if[0])
  );

  bd_prog_reformatter #(
    .leaf_code   (bd_pkg::code_pat),
    .half_width  (pat_half_width),
    .chunk_width (pat_chunk_width)
  ) i_pat (
    .clk        (clk),
    .rst        (rst),
    .halves_in  (prog_if[1]),
    .chunks_out (chunk_if[1])
  );

  bd_prog_reformatter #(
    .leaf_code   (bd_pkg::code_tat0),
    .half_width  (tat0_half_width),
    .chunk_width (tat0_chunk_width)
  ) i_tat0 (
    .clk        (clk),
    .rst        (rst),
    .halves_in  (prog_if[2]),
    .chunks_out (chunk_if[2])
  );

  bd_prog_reformatter #(
    .leaf_code   (bd_pkg::code_tat1),
    .half_width  (tat1_half_width),
    .chunk_width (tat1_chunk_width)
  ) i_tat1 (
    .clk        (clk),
    .rst        (rst),
    .halves_in  (prog_if[3]),
    .chunks_out (chunk_if[3])
  );

  ////////////////////////////////////////////////////////////
  // merge and encode

  // gather the five lanes into one array for the arbiter
  for (genvar i = 0; i < 4; i++) begin : g_chunk_lane
    assign lane_if[i].valid = chunk_if[i].valid;
    assign lane_if[i].word  = chunk_if[i].word;
    assign chunk_if[i].ack  = lane_if[i].ack;
  end

  assign lane_if[4].valid = bypass_if.valid;
  assign lane_if[4].word  = bypass_if.word;
  assign bypass_if.ack    = lane_if[4].ack;

  bd_word_arbiter i_arbiter (
    .clk        (clk),
    .rst        (rst),
    .lanes_in   (lane_if),
    .merged_out (merged_if)
  );

  bd_funnel_encoder i_funnel (
    .words_in (merged_if),
    .bd_valid (out_valid),
    .bd_data  (out_data),
    .bd_ack   (out_ack)
  );

endmodule

`default_nettype wire

//--- verif/bd_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

// free-running testbench clock
// starts low, first rising edge after half a period
module bd_clock_gen #(
  parameter int unsigned period_ns = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // half period high, half period low
  always #(period_ns / 2) begin
    clk = ~clk;
  end

endmodule

`default_nettype wire

//--- verif/bd_encoder_tb.sv
`timescale 1ns/100ps
`default_nettype none

// table-driven testbench for the downstream encoder
// pass 0 holds out_ack high and pass 1 toggles it from an lfsr
module bd_encoder_tb;

  ////////////////////////////////////////////////////////////
  // stimulus table

  // code, first payload and second payload (programming leaves only)
  typedef struct packed {
    logic [bd_pkg::n_code-1:0]    code;
    logic [bd_pkg::n_payload-1:0] p0;
    logic [bd_pkg::n_payload-1:0] p1;
  } stim_t;

  localparam int unsigned n_entries    = 14;
  localparam int unsigned n_passes     = 2;
  localparam int unsigned reset_cycles = 16;
  localparam int unsigned drain_cycles = 20;
  // 40 cycles per entry per pass, plus reset and the final drain
  localparam int unsigned timeout_cycles =
    n_passes * n_entries * 40 + reset_cycles + drain_cycles;

  localparam stim_t stim_table [n_entries] = '{
    '{6'd30, 24'h0A5A5A, 24'h000000},  // ri with one route bit
    '{6'd1,  24'h0003FF, 24'h000000},  // dac[0]
    '{6'd26, 24'h1ABCDE, 24'h0F1234},  // ammm
    '{6'd27, 24'h003A5C, 24'h001FFF},  // pat
    '{6'd28, 24'h00BEEF, 24'h00CAFE},  // tat0
    '{6'd29, 24'h00F00D, 24'h001234},  // tat1
    '{6'd40, 24'h123456, 24'h000000},  // bad code that is dropped
    '{6'd0,  24'h00ABCD, 24'h000000},  // adc
    '{6'd63, 24'hFFFFFF, 24'h000000},  // bad code that is dropped
    '{6'd23, 24'h03FFFF, 24'h000000},  // neuron config
    '{6'd33, 24'h000FFF, 24'h000000},  // last valid leaf
    '{6'd34, 24'h00AAAA, 24'h000000},  // first bad code
    '{6'd14, 24'h0001C3, 24'h000000},  // delay[0]
    '{6'd26, 24'hFFFFFF, 24'h155555}   // ammm with upper bits ignored
  };

  logic                         clk;
  logic                         rst;
  logic                         in_valid;
  logic [bd_pkg::n_code-1:0]    in_code;
  logic [bd_pkg::n_payload-1:0] in_payload;
  logic                         in_ack;
  logic                         out_valid;
  logic [bd_pkg::n_bd_data-1:0] out_data;
  logic                         out_ack = 1'b0;

  logic                         random_ack = 1'b0;
  logic [15:0]                  lfsr_state = 16'd57202;
  int unsigned                  cycle_count = 0;
  logic [bd_pkg::n_bd_data-1:0] want_word;
  logic [bd_pkg::n_bd_data-1:0] expected_q [$];

  bd_clock_gen #(.period_ns(4)) i_clock (.clk(clk));

  bd_encoder i_dut (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_code    (in_code),
    .in_payload (in_payload),
    .in_ack     (in_ack),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_ack    (out_ack)
  );

  ////////////////////////////////////////////////////////////
  // reference model

  // 16-bit galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  function automatic bit is_prog_leaf(input logic [bd_pkg::n_code-1:0] code);
    return (code >= 6'd26) && (code <= 6'd29);
  endfunction

  // route in the low bits and the payload above it
  function automatic logic [bd_pkg::n_bd_data-1:0] chip_word(
    input logic [bd_pkg::n_code-1:0]    code,
    input logic [bd_pkg::n_payload-1:0] payload
  );
    logic [31:0] wide;
    wide = {8'd0, payload} << bd_pkg::route_len_table[code];
    wide = wide | {24'd0, bd_pkg::route_table[code]};
    return wide[bd_pkg::n_bd_data-1:0];
  endfunction

  // chunk idx of a programming word with per-lane half and chunk widths
  function automatic logic [bd_pkg::n_payload-1:0] prog_chunk(
    input logic [bd_pkg::n_code-1:0]    code,
    input logic [bd_pkg::n_payload-1:0] p0,
    input logic [bd_pkg::n_payload-1:0] p1,
    input int unsigned                  idx
  );
    int unsigned                  hw;
    int unsigned                  cw;
    logic [bd_pkg::n_payload-1:0] half;
    case (code)
      6'd26: begin
        hw = 21;
        cw = 11;
      end
      6'd27: begin
        hw = 14;
        cw = 7;
      end
      default: begin
        hw = 16;
        cw = 8;
      end
    endcase
    half = ((idx < 2) ? p0 : p1) & ((24'd1 << hw) - 24'd1);
    // even chunks are the low part and odd ones the zero-padded rest
    if (idx % 2 == 0) begin
      return half & ((24'd1 << cw) - 24'd1);
    end
    return half >> cw;
  endfunction

  task automatic push_expected(input stim_t s);
    if (s.code >= bd_pkg::n_leaves) begin
      // dropped by the funnel so nothing is expected
    end else if (is_prog_leaf(s.code)) begin
      for (int unsigned i = 0; i < 4; i++) begin
        expected_q.push_back(chip_word(s.code, prog_chunk(s.code, s.p0, s.p1, i)));
      end
    end else begin
      expected_q.push_back(chip_word(s.code, s.p0));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_bd_data(
    input logic [bd_pkg::n_bd_data-1:0] expected,
    input logic [bd_pkg::n_bd_data-1:0] actual,
    input string                        name
  );
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      $display("test failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // drivers and monitors

  // host side driver that starts and ends on a falling edge
  task automatic send_word(
    input logic [bd_pkg::n_code-1:0]    code,
    input logic [bd_pkg::n_payload-1:0] payload
  );
    bit accepted;
    accepted   = 1'b0;
    in_valid   = 1'b1;
    in_code    = code;
    in_payload = payload;
    while (!accepted) begin
      @(posedge clk);
      accepted = in_ack;
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic run_entry(input stim_t s);
    push_expected(s);
    if (is_prog_leaf(s.code)) begin
      send_word(s.code, s.p0);
      send_word(s.code, s.p1);
    end else begin
      send_word(s.code, s.p0);
    end
    // wait for every modeled word
    while (expected_q.size() != 0) begin
      @(negedge clk);
    end
    // a leaked word would sit on out_valid one cycle after its transfer
    @(negedge clk);
  endtask

  // chip side back-pressure with one lfsr step per ack bit
  always @(negedge clk) begin
    if (random_ack) begin
      out_ack    <= lfsr_state[0];
      lfsr_state <= lfsr_next(lfsr_state);
    end else begin
      out_ack <= 1'b1;
    end
  end

  // every output transfer must match the head of the model queue
  always @(posedge clk) begin
    if (!rst && out_valid) begin
      if (expected_q.size() == 0) begin
        $display("extra chip word %h at %0t ns with nothing pending", out_data, $time);
        $display("test failed");
        $fatal(1, "unexpected output");
      end else if (out_ack) begin
        want_word = expected_q.pop_front();
        check_bd_data(want_word, out_data, "out_data");
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout after %0d cycles, the encoder stopped moving words", cycle_count);
      $display("test failed");
      $fatal(1, "run aborted");
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_code    = '0;
    in_payload = '0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // same table twice with random out_ack the second time
    for (int unsigned pass = 0; pass < n_passes; pass++) begin
      random_ack <= (pass == 1);
      for (int unsigned e = 0; e < n_entries; e++) begin
        run_entry(stim_table[e]);
      end
    end

    // idle tail where any late word shows up as an extra
    repeat (drain_cycles) @(negedge clk);
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
hdl/bd_pkg.sv
hdl/bd_word_if.sv
hdl/bd_leaf_splitter.sv
hdl/bd_prog_reformatter.sv
hdl/bd_word_arbiter.sv
hdl/bd_funnel_encoder.sv
hdl/bd_encoder.sv
verif/bd_clock_gen.sv
verif/bd_encoder_tb.sv
